/* logic/MipsIsaPkg.sv */
package MipsIsaPkg;

    localparam int InstrWidth     = 32;   // Every instruction is one word
    localparam int OpcodeMsb      = 31;   // Major opcode field, top six bits
    localparam int OpcodeLsb      = 26;
    localparam int FunctMsb       = 5;    // Function field sits in bits 5..0
    localparam int JumpIndexWidth = 26;   // Word index carried by j and jal

    // Major opcodes seen by the fetch front end
    typedef enum logic [5:0] {
        OpSpecial = 6'h00,                // R-type, look at funct
        OpJ       = 6'h02,
        OpJal     = 6'h03,
        OpBeq     = 6'h04,
        OpBne     = 6'h05,
        OpAddi    = 6'h08,
        OpLw      = 6'h23,
        OpSw      = 6'h2B
    } Opcode;

    // Function codes under OpSpecial
    typedef enum logic [5:0] {
        FnJr   = 6'h08,
        FnJalr = 6'h09,
        FnAdd  = 6'h20,
        FnSub  = 6'h22
    } Funct;

    // Coarse class attached to each fetched word
    typedef enum logic [2:0] {
        KindAlu      = 3'd0,              // add, sub, addi
        KindLoad     = 3'd1,
        KindStore    = 3'd2,
        KindBranch   = 3'd3,              // beq, bne, resolved later
        KindJump     = 3'd4,              // j, target known at fetch
        KindJumpLink = 3'd5,              // jal, target known at fetch
        KindJumpReg  = 3'd6,              // jr, jalr, redirected from outside
        KindUnknown  = 3'd7
    } InstrKind;

endpackage

/* logic/FetchPkg.sv */
package FetchPkg;

    localparam int AddrWidth      = 32;                        // Byte address width
    localparam int MemWords       = 512;                       // Instruction storage depth
    localparam int WordIndexWidth = 9;                         // Address bits 10..2
    localparam logic [AddrWidth-1:0] ResetVector = '0;         // First fetch address
    localparam int CreditCount    = 4;                         // Decoder buffer entries
    localparam int CreditWidth    = $clog2(CreditCount + 1);   // Holds 0..CreditCount

    // One fetched word on its way to decode
    typedef struct packed {
        logic [AddrWidth-1:0]             pc;
        logic [MipsIsaPkg::InstrWidth-1:0] instruction;
        MipsIsaPkg::InstrKind             kind;
    } FetchPacket;

    // Fetch redirect from execute (taken branch, jr, jalr)
    typedef struct packed {
        logic                 valid;
        logic [AddrWidth-1:0] target;
    } RedirectRequest;

    // Direct jump resolved by the predecoder
    typedef struct packed {
        logic                 valid;
        logic [AddrWidth-1:0] target;
    } JumpRedirect;

endpackage

/* logic/ProgramCounter.sv */
`timescale 1ns/1ps

module ProgramCounter (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           issueAllowed,   // Credit available this cycle
    input  FetchPkg::RedirectRequest       redirect,       // From execute stage
    input  FetchPkg::JumpRedirect          jumpRedirect,   // From predecoder
    output logic                           issueValid,
    output logic [FetchPkg::AddrWidth-1:0] issueAddr
);

    logic [FetchPkg::AddrWidth-1:0] fetchPc;   // Address of the next sequential fetch
    logic [FetchPkg::AddrWidth-1:0] nextPc;

    // Outside redirect beats a direct jump
    // A jump beats the sequential address
    always_comb begin
        if (redirect.valid) begin
            issueAddr = redirect.target;
        end else if (jumpRedirect.valid) begin
            issueAddr = jumpRedirect.target;   // Same cycle as the jump word returns
        end else begin
            issueAddr = fetchPc;
        end
    end

    assign issueValid = issueAllowed;   // Issue whenever a credit is free

    // Step past an issued word, otherwise keep the chosen address
    // so a redirect or jump seen under back-pressure is not lost
    always_comb begin
        if (issueValid) begin
            nextPc = issueAddr + FetchPkg::AddrWidth'(4);
        end else begin
            nextPc = issueAddr;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            fetchPc <= FetchPkg::ResetVector;
        end else begin
            fetchPc <= nextPc;
        end
    end

endmodule

/* logic/InstructionMemory.sv */
`timescale 1ns/1ps

module InstructionMemory (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                issueValid,
    input  logic [FetchPkg::AddrWidth-1:0]      issueAddr,
    input  FetchPkg::RedirectRequest            redirect,
    output logic                                readValid,
    output logic [FetchPkg::AddrWidth-1:0]      readPc,     // Address of the returning word
    output logic [MipsIsaPkg::InstrWidth-1:0]   readData
);

    logic [MipsIsaPkg::InstrWidth-1:0] memory [FetchPkg::MemWords];   // Word storage
    logic                              readPending;   // A read was issued last cycle

    initial begin
        $readmemh("logic/program.mem", memory);   // Program image
    end

    // Registered read, word select drops the byte offset
    always_ff @(posedge clk) begin
        if (issueValid) begin
            readData <= memory[issueAddr[FetchPkg::WordIndexWidth+1:2]];
            readPc   <= issueAddr;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            readPending <= 1'b0;
        end else begin
            readPending <= issueValid;
        end
    end

    // A redirect kills the word coming back in the same cycle
    assign readValid = readPending && !redirect.valid;

endmodule

/* logic/JumpPredecoder.sv */
`timescale 1ns/1ps

module JumpPredecoder (
    input  logic                              readValid,
    input  logic [FetchPkg::AddrWidth-1:0]    readPc,
    input  logic [MipsIsaPkg::InstrWidth-1:0] readData,
    output logic                              predecodedValid,
    output FetchPkg::FetchPacket              predecoded,
    output FetchPkg::JumpRedirect             jumpRedirect
);

    MipsIsaPkg::Opcode              opcode;
    MipsIsaPkg::Funct               funct;
    MipsIsaPkg::InstrKind           kind;
    logic [FetchPkg::AddrWidth-1:0] pcPlus4;   // Jump region comes from the next PC

    assign opcode  = MipsIsaPkg::Opcode'(readData[MipsIsaPkg::OpcodeMsb:MipsIsaPkg::OpcodeLsb]);
    assign funct   = MipsIsaPkg::Funct'(readData[MipsIsaPkg::FunctMsb:0]);
    assign pcPlus4 = readPc + FetchPkg::AddrWidth'(4);

    // Opcode and funct to instruction class
    always_comb begin
        case (opcode)
            MipsIsaPkg::OpSpecial: begin
                case (funct)
                    MipsIsaPkg::FnAdd,
                    MipsIsaPkg::FnSub:  kind = MipsIsaPkg::KindAlu;
                    MipsIsaPkg::FnJr,
                    MipsIsaPkg::FnJalr: kind = MipsIsaPkg::KindJumpReg;   // Target from a register
                    default:            kind = MipsIsaPkg::KindUnknown;
                endcase
            end
            MipsIsaPkg::OpAddi: kind = MipsIsaPkg::KindAlu;
            MipsIsaPkg::OpLw:   kind = MipsIsaPkg::KindLoad;
            MipsIsaPkg::OpSw:   kind = MipsIsaPkg::KindStore;
            MipsIsaPkg::OpBeq,
            MipsIsaPkg::OpBne:  kind = MipsIsaPkg::KindBranch;   // Condition unknown here
            MipsIsaPkg::OpJ:    kind = MipsIsaPkg::KindJump;
            MipsIsaPkg::OpJal:  kind = MipsIsaPkg::KindJumpLink;
            default:            kind = MipsIsaPkg::KindUnknown;
        endcase
    end

    // Direct jumps redirect fetch right away
    always_comb begin
        jumpRedirect.valid  = readValid &&
                              (kind == MipsIsaPkg::KindJump || kind == MipsIsaPkg::KindJumpLink);
        jumpRedirect.target = {pcPlus4[FetchPkg::AddrWidth-1:FetchPkg::AddrWidth-4],
                               readData[MipsIsaPkg::JumpIndexWidth-1:0],
                               2'b00};   // Word aligned
    end

    always_comb begin
        predecodedValid        = readValid;
        predecoded.pc          = readPc;
        predecoded.instruction = readData;
        predecoded.kind        = kind;
    end

endmodule

/* logic/DecodeLink.sv */
`timescale 1ns/1ps

module DecodeLink (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     issueValid,        // Read issued this cycle
    input  logic                     predecodedValid,   // Read returned and not squashed
    input  FetchPkg::FetchPacket     predecoded,
    input  logic                     creditReturn,      // One buffer entry freed downstream
    input  FetchPkg::RedirectRequest redirect,
    output logic                     issueAllowed,
    output logic                     packetValid,
    output FetchPkg::FetchPacket     packet
);

    logic [FetchPkg::CreditWidth-1:0] credits;       // Free decoder entries
    logic [FetchPkg::CreditWidth-1:0] creditsNext;
    logic [1:0]                       inFlight;      // Reads between issue and return
    logic [1:0]                       inFlightNext;
    logic                             retire;        // An in-flight read leaves this cycle
    logic [FetchPkg::CreditWidth-1:0] pendingNext;   // Claims on credits next cycle

    // Read leaves by returning or by being squashed
    assign retire = predecodedValid || (redirect.valid && inFlight != 2'd0);

    always_comb begin
        inFlightNext = inFlight + 2'(issueValid) - 2'(retire);
        creditsNext  = credits + FetchPkg::CreditWidth'(creditReturn)
                               - FetchPkg::CreditWidth'(packetValid);   // Presented packet spends one
        pendingNext  = FetchPkg::CreditWidth'(inFlightNext)
                     + FetchPkg::CreditWidth'(predecodedValid);         // Packet register counts too
    end

    // Control state
    always_ff @(posedge clk) begin
        if (reset) begin
            credits      <= FetchPkg::CreditWidth'(FetchPkg::CreditCount);
            inFlight     <= 2'd0;
            issueAllowed <= 1'b0;
            packetValid  <= 1'b0;
        end else begin
            credits      <= creditsNext;
            inFlight     <= inFlightNext;
            issueAllowed <= creditsNext > pendingNext;   // A credit left after every claim
            packetValid  <= predecodedValid;
        end
    end

    // Packet register toward the decoder
    always_ff @(posedge clk) begin
        if (predecodedValid) begin
            packet <= predecoded;
        end
    end

endmodule

/* logic/FetchUnit.sv */
`timescale 1ns/1ps

module FetchUnit (
    input  logic                     clk,
    input  logic                     reset,
    input  FetchPkg::RedirectRequest redirect,       // Taken branch, jr or jalr from execute
    input  logic                     creditReturn,   // One decoder entry freed
    output logic                     packetValid,
    output FetchPkg::FetchPacket     packet
);

    logic                              issueValid;        // Read request this cycle
    logic [FetchPkg::AddrWidth-1:0]    issueAddr;
    logic                              issueAllowed;      // Credit left after in-flight reads
    logic                              readValid;         // Word back from memory, not squashed
    logic [FetchPkg::AddrWidth-1:0]    readPc;
    logic [MipsIsaPkg::InstrWidth-1:0] readData;
    FetchPkg::JumpRedirect             jumpRedirect;      // Direct jump target, same cycle
    logic                              predecodedValid;
    FetchPkg::FetchPacket              predecoded;

    // Input side
    ProgramCounter programCounter (
        .clk          (clk),
        .reset        (reset),
        .issueAllowed (issueAllowed),
        .redirect     (redirect),
        .jumpRedirect (jumpRedirect),
        .issueValid   (issueValid),
        .issueAddr    (issueAddr)
    );

    InstructionMemory instructionMemory (
        .clk        (clk),
        .reset      (reset),
        .issueValid (issueValid),
        .issueAddr  (issueAddr),
        .redirect   (redirect),     // Squashes the read returning now
        .readValid  (readValid),
        .readPc     (readPc),
        .readData   (readData)
    );

    JumpPredecoder jumpPredecoder (
        .readValid       (readValid),
        .readPc          (readPc),
        .readData        (readData),
        .predecodedValid (predecodedValid),
        .predecoded      (predecoded),
        .jumpRedirect    (jumpRedirect)
    );

    // Output side toward the decoder
    DecodeLink decodeLink (
        .clk             (clk),
        .reset           (reset),
        .issueValid      (issueValid),
        .predecodedValid (predecodedValid),
        .predecoded      (predecoded),
        .creditReturn    (creditReturn),
        .redirect        (redirect),
        .issueAllowed    (issueAllowed),
        .packetValid     (packetValid),
        .packet          (packet)
    );

endmodule

/* tests/FetchUnit_checker.sv */
`timescale 1ns/1ps

module FetchUnit_checker (
    input logic clk,
    input logic reset,
    input logic packetValid,
    input logic creditReturn,
    input logic issueValid
);

    logic [FetchPkg::CreditWidth:0] creditsUsed;   // One spare bit so overflow shows
    logic                           issuedLast;    // Read issued last cycle, may become a packet

    // Packets presented minus credits given back
    always_ff @(posedge clk) begin
        if (reset) begin
            creditsUsed <= '0;
            issuedLast  <= 1'b0;
        end else begin
            creditsUsed <= creditsUsed
                         + (FetchPkg::CreditWidth+1)'(packetValid)
                         - (FetchPkg::CreditWidth+1)'(creditReturn);
            issuedLast  <= issueValid;
        end
    end

    creditsBounded: assert property (@(posedge clk) disable iff (reset)
        creditsUsed <= (FetchPkg::CreditWidth+1)'(FetchPkg::CreditCount))
        else $error("decoder holds more packets than it has entries");

    // First cycle out of reset shows no packet
    quietAfterReset: assert property (@(posedge clk) $fell(reset) |-> !packetValid)
        else $error("packet presented in the first cycle after reset");

    // Held packets, the packet on the wire and the read in flight all claim a credit
    issueNeedsCredit: assert property (@(posedge clk) disable iff (reset)
        issueValid |-> creditsUsed
                       + (FetchPkg::CreditWidth+1)'(packetValid)
                       + (FetchPkg::CreditWidth+1)'(issuedLast)
                       < (FetchPkg::CreditWidth+1)'(FetchPkg::CreditCount))
        else $error("read issued without a free credit");

endmodule

bind FetchUnit FetchUnit_checker checks (
    .clk          (clk),
    .reset        (reset),
    .packetValid  (packetValid),
    .creditReturn (creditReturn),
    .issueValid   (issueValid)
);

/* tests/FetchUnitTb.sv */
`timescale 1ns/1ps

module FetchUnitTb;

    localparam int PlannedPackets = 400;
    localparam int TimeoutCycles  = 8 * PlannedPackets + 200;   // 3400 cycles
    localparam int StallCycles    = 40;                         // Long enough to drain four

    logic                     clk = 1'b0;
    logic                     reset;
    FetchPkg::RedirectRequest redirect;
    logic                     creditReturn;
    logic                     packetValid;
    FetchPkg::FetchPacket     packet;

    logic [31:0] programImage [FetchPkg::MemWords];   // Same image the DUT loads
    logic [31:0] expectedPc = FetchPkg::ResetVector;
    logic [31:0] expectedWord;
    logic [15:0] lfsrState;
    logic [15:0] bits;
    logic        giveCredit;
    logic        stallDone = 1'b0;      // Set once the no-return window is over
    logic        stallChecked = 1'b0;
    int          receivedCount = 0;     // Packets seen at the decoder
    int          returnedCount = 0;     // Credits handed back
    int          errorCount = 0;
    int          cycleCount = 0;
    int          cooldown;              // Cycles until the next redirect may fire

    FetchUnit i_FetchUnit (
        .clk          (clk),
        .reset        (reset),
        .redirect     (redirect),
        .creditReturn (creditReturn),
        .packetValid  (packetValid),
        .packet       (packet)
    );

    always #50 clk = ~clk;   // 100 ns period

    initial begin
        $readmemh("logic/program.mem", programImage);
    end

    // 16-bit Fibonacci LFSR, taps 16 14 13 11
    function automatic logic [15:0] lfsrNext(input logic [15:0] state);
        logic feedback;
        feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
        return {state[14:0], feedback};
    endfunction

    // One LFSR step per bit taken
    function automatic logic [15:0] randomBits(input int count);
        logic [15:0] result;
        result = '0;
        for (int i = 0; i < count; i++) begin
            lfsrState = lfsrNext(lfsrState);
            result    = {result[14:0], lfsrState[0]};
        end
        return result;
    endfunction

    // Class of a word from the MIPS opcode and funct fields
    function automatic MipsIsaPkg::InstrKind expectedKind(input logic [31:0] word);
        MipsIsaPkg::InstrKind kind;
        case (word[31:26])
            6'h00: begin
                case (word[5:0])
                    6'h20, 6'h22: kind = MipsIsaPkg::KindAlu;       // add, sub
                    6'h08, 6'h09: kind = MipsIsaPkg::KindJumpReg;   // jr, jalr
                    default:      kind = MipsIsaPkg::KindUnknown;
                endcase
            end
            6'h08:        kind = MipsIsaPkg::KindAlu;      // addi
            6'h23:        kind = MipsIsaPkg::KindLoad;
            6'h2B:        kind = MipsIsaPkg::KindStore;
            6'h04, 6'h05: kind = MipsIsaPkg::KindBranch;
            6'h02:        kind = MipsIsaPkg::KindJump;
            6'h03:        kind = MipsIsaPkg::KindJumpLink;
            default:      kind = MipsIsaPkg::KindUnknown;
        endcase
        return kind;
    endfunction

    // Next PC in program order, direct jumps taken at once
    function automatic logic [31:0] followPc(input logic [31:0] pc, input logic [31:0] word);
        logic [31:0] pcPlus4;
        MipsIsaPkg::InstrKind kind;
        pcPlus4 = pc + 32'd4;
        kind    = expectedKind(word);
        if (kind == MipsIsaPkg::KindJump || kind == MipsIsaPkg::KindJumpLink) begin
            return {pcPlus4[31:28], word[25:0], 2'b00};
        end
        return pcPlus4;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            $display("ERROR %s: got %h, expected %h", name, actual, expected);
            errorCount = errorCount + 1;
        end
    endtask

    // Inputs for the coming cycle
    task automatic driveInputs(input logic credit, input logic jump, input logic [31:0] target);
        creditReturn    <= credit;
        redirect.valid  <= jump;
        redirect.target <= jump ? target : 32'd0;
        if (credit) begin
            returnedCount = returnedCount + 1;
        end
    endtask

    // Compare process, mid-cycle when outputs are settled
    always @(negedge clk) begin
        if (reset) begin
            checkValue("packetValid", 32'(packetValid), 32'd0);   // Nothing during reset
        end else begin
            if (packetValid) begin
                expectedWord = programImage[expectedPc[FetchPkg::WordIndexWidth+1:2]];
                checkValue("packet.pc", packet.pc, expectedPc);
                checkValue("packet.instruction", packet.instruction, expectedWord);
                checkValue("packet.kind", 32'(packet.kind), 32'(expectedKind(expectedWord)));
                expectedPc    = followPc(expectedPc, expectedWord);
                receivedCount = receivedCount + 1;
                if (receivedCount - returnedCount > FetchPkg::CreditCount) begin
                    $display("More than %0d packets are outstanding at the decoder",
                             FetchPkg::CreditCount);
                    errorCount = errorCount + 1;
                end
            end
            if (redirect.valid) begin
                expectedPc = redirect.target;   // Later packets follow the new path
            end
            if (stallDone && !stallChecked) begin
                checkValue("stalledPackets", 32'(receivedCount - returnedCount),
                           32'(FetchPkg::CreditCount));
                stallChecked = 1'b1;
            end
        end
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
    end

    initial begin
        while (cycleCount < TimeoutCycles) begin
            @(posedge clk);
        end
        $display("Timeout: the run did not finish within %0d cycles", TimeoutCycles);
        $display("Closing: %0d errors, %0d packets", errorCount, receivedCount);
        $display("test failed");
        $finish;
    end

    initial begin
        reset        = 1'b1;
        creditReturn = 1'b0;
        redirect     = '0;
        lfsrState    = 16'd47;   // Seed
        cooldown     = 0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;

        // Credits come back as soon as a packet is held
        while (receivedCount < 150) begin
            @(posedge clk);
            driveInputs(receivedCount > returnedCount, 1'b0, 32'd0);
        end

        // Random credit withholding and outside redirects
        while (receivedCount < 350) begin
            @(posedge clk);
            bits       = randomBits(1);
            giveCredit = bits[0] && (receivedCount > returnedCount);
            bits       = randomBits(3);
            if (cooldown == 0 && bits[2:0] == 3'd0) begin
                bits     = randomBits(9);
                cooldown = 6;
                driveInputs(giveCredit, 1'b1, {21'd0, bits[8:0], 2'b00});
            end else begin
                if (cooldown > 0) begin
                    cooldown = cooldown - 1;
                end
                driveInputs(giveCredit, 1'b0, 32'd0);
            end
        end

        // Give every credit back, then none at all
        while (receivedCount > returnedCount) begin
            @(posedge clk);
            driveInputs(1'b1, 1'b0, 32'd0);
        end
        repeat (StallCycles) begin
            @(posedge clk);
            driveInputs(1'b0, 1'b0, 32'd0);
        end
        stallDone = 1'b1;

        // Resume and finish the planned count
        while (receivedCount < PlannedPackets) begin
            @(posedge clk);
            driveInputs(receivedCount > returnedCount, 1'b0, 32'd0);
        end

        if (!stallChecked) begin
            $display("The stall window was never checked");
        end
        $display("Closing: %0d errors, %0d packets", errorCount, receivedCount);
        if (errorCount == 0 && stallChecked) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* logic/program.mem */
// One 32-bit instruction word per line in hex, loaded from word address 0
// Loop path 0..8, jal to 12, 12..15, j to 18, 18..19, j to 0
20010005 // addi $1, $0, 5
20020003 // addi $2, $0, 3
00221820 // add  $3, $1, $2
00222022 // sub  $4, $1, $2
AC030000 // sw   $3, 0($0)
8C050000 // lw   $5, 0($0)
10A30002 // beq  $5, $3, 2
1422FFFF // bne  $1, $2, -1
0C00000C // jal  12
20060001 // addi $6, $0, 1
03E00008 // jr   $31
FFFFFFFF // not a valid encoding
00213820 // add  $7, $1, $1
00E0F809 // jalr $31, $7
8C080004 // lw   $8, 4($0)
08000012 // j    18
00431022 // sub  $2, $2, $3
AC080008 // sw   $8, 8($0)
20090007 // addi $9, $0, 7
08000000 // j    0

/* FetchUnit.f */
logic/MipsIsaPkg.sv
logic/FetchPkg.sv
logic/ProgramCounter.sv
logic/InstructionMemory.sv
logic/JumpPredecoder.sv
logic/DecodeLink.sv
logic/FetchUnit.sv
tests/FetchUnit_checker.sv
tests/FetchUnitTb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the fetch unit testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert -j 0 \
        --top-module FetchUnitTb -f FetchUnit.f -o FetchUnitSim; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/FetchUnitSim > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "test failed" "$LOG"; then
    echo "Simulation reported failure"
    exit 1
fi

echo "Simulation finished without failure"
exit 0
